/* logic/trace_pkg.sv */
/*
 * Retirement trace unit shared definitions.
 * Widths, queue depth, commit event kinds and counter selects.
 */

`default_nettype none

package trace_pkg;

  // ------------------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------------------
  localparam int unsigned NR_COMMIT_PORTS = 2;
  localparam int unsigned VLEN            = 32;
  // top bit of the cause flags an interrupt
  localparam int unsigned CAUSE_W         = 32;
  localparam int unsigned PC_QUEUE_DEPTH  = 4;
  localparam int unsigned CNT_W           = 32;

  typedef logic [0:0] port_idx_t;

  // ------------------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    EV_NONE      = 2'd0,
    EV_RETIRE    = 2'd1,
    EV_EXCEPTION = 2'd2,
    EV_INTERRUPT = 2'd3
  } event_kind_e;

  typedef enum logic [1:0] {
    CNT_RETIRED   = 2'd0,
    CNT_EXCEPTION = 2'd1,
    CNT_INTERRUPT = 2'd2,
    CNT_DROPPED   = 2'd3
  } cnt_sel_e;

endpackage

`default_nettype wire

/* logic/commit_event_if.sv */
/*
 * Commit event bundle. Carries the classified commit of each port and
 * the debug mode flag sampled in the same cycle.
 */

`timescale 1ns/1ns
`default_nettype none

interface commit_event_if;

  // one entry per commit port that is valid for a single cycle
  trace_pkg::event_kind_e [trace_pkg::NR_COMMIT_PORTS-1:0]      ev_kind;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0]    ev_pc;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::CAUSE_W-1:0] ev_cause;
  logic                                                          debug_mode;

  // classifier side
  modport src (output ev_kind, ev_pc, ev_cause, debug_mode);

  // queues and counters
  modport dst (input ev_kind, ev_pc, ev_cause, debug_mode);

endinterface

`default_nettype wire

/* logic/commit_classify.sv */
/*
 * Commit classifier. Registers the raw commit ports and turns each
 * acknowledged commit into a retire, exception or interrupt event.
 */

`timescale 1ns/1ns
`default_nettype none

module commit_classify (
  input  wire logic                                                          clk_i,
  input  wire logic                                                          rst_ni,
  input  wire logic [trace_pkg::NR_COMMIT_PORTS-1:0]                         commit_ack_i,
  input  wire logic [trace_pkg::NR_COMMIT_PORTS-1:0]                         commit_ex_valid_i,
  input  wire logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0]    commit_pc_i,
  input  wire logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::CAUSE_W-1:0] commit_cause_i,
  input  wire logic                                                          debug_mode_i,
  commit_event_if.src                                                        ev
);

  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                         ack_q;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                         ex_q;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0]    pc_q;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::CAUSE_W-1:0] cause_q;
  logic                                                          debug_q;

  // ------------------------------------------------------------------------
  // input registers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= '0;
      ex_q    <= '0;
      debug_q <= 1'b0;
    end else begin
      ack_q   <= commit_ack_i;
      ex_q    <= commit_ex_valid_i;
      debug_q <= debug_mode_i;
    end
  end

  always_ff @(posedge clk_i) begin
    pc_q    <= commit_pc_i;
    cause_q <= commit_cause_i;
  end

  // ------------------------------------------------------------------------
  // classification
  // ------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
      if (!ack_q[i]) begin
        ev.ev_kind[i] = trace_pkg::EV_NONE;
      end else if (!ex_q[i]) begin
        ev.ev_kind[i] = trace_pkg::EV_RETIRE;
      end else if (cause_q[i][trace_pkg::CAUSE_W-1]) begin
        // msb of the cause marks an asynchronous trap
        ev.ev_kind[i] = trace_pkg::EV_INTERRUPT;
      end else begin
        ev.ev_kind[i] = trace_pkg::EV_EXCEPTION;
      end
    end
  end

  assign ev.ev_pc      = pc_q;
  assign ev.ev_cause   = cause_q;
  assign ev.debug_mode = debug_q;

endmodule

`default_nettype wire

/* logic/pc_queue.sv */
/*
 * Retired PC queue for one commit port. Circular buffer with an
 * occupancy count, drops and flags a push that meets a full queue.
 */

`timescale 1ns/1ns
`default_nettype none

module pc_queue #(
  parameter trace_pkg::port_idx_t PORT  = '0,
  parameter int unsigned          DEPTH = trace_pkg::PC_QUEUE_DEPTH
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  commit_event_if.dst                     ev,
  input  wire logic                       pop_i,
  output logic                            head_valid_o,
  output logic [trace_pkg::VLEN-1:0]      head_pc_o,
  output logic                            drop_o
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  logic [trace_pkg::VLEN-1:0] mem_q [DEPTH];
  ptr_t                       rd_ptr_q;
  ptr_t                       wr_ptr_q;
  cnt_t                       count_q;
  logic                       push;
  logic                       full;
  logic                       do_push;
  logic                       do_pop;

  // only retired instructions of this port enter the queue
  assign push    = (ev.ev_kind[PORT] == trace_pkg::EV_RETIRE);
  assign full    = (count_q == cnt_t'(DEPTH));
  assign do_pop  = pop_i && head_valid_o;
  // a pop in the same cycle frees the slot for the incoming PC
  assign do_push = push && (!full || do_pop);
  assign drop_o  = push && full && !do_pop;

  assign head_valid_o = (count_q != '0);
  assign head_pc_o    = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= ev.ev_pc[PORT];
    end
  end

  // ------------------------------------------------------------------------
  // pointers and occupancy
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/retire_counters.sv */
/*
 * Retirement event counters. Counts retired instructions, exceptions,
 * interrupts and dropped PCs, frozen in debug mode, read by select.
 */

`timescale 1ns/1ns
`default_nettype none

module retire_counters (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  commit_event_if.dst                                ev,
  input  wire logic [trace_pkg::NR_COMMIT_PORTS-1:0] drop_i,
  input  wire trace_pkg::cnt_sel_e                   cnt_sel_i,
  input  wire logic                                  cnt_clear_i,
  output logic [trace_pkg::CNT_W-1:0]                cnt_rdata_o
);

  // one counter per select value
  logic [3:0][trace_pkg::CNT_W-1:0] cnt_q;
  // up to two ports hit the same counter in a cycle
  logic [3:0][1:0]                  inc;

  // ------------------------------------------------------------------------
  // per-cycle increments
  // ------------------------------------------------------------------------
  always_comb begin
    inc = '0;
    for (int i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin
      unique case (ev.ev_kind[i])
        trace_pkg::EV_RETIRE:    inc[trace_pkg::CNT_RETIRED]   += 2'd1;
        trace_pkg::EV_EXCEPTION: inc[trace_pkg::CNT_EXCEPTION] += 2'd1;
        trace_pkg::EV_INTERRUPT: inc[trace_pkg::CNT_INTERRUPT] += 2'd1;
        default: ;
      endcase
      if (drop_i[i]) begin
        inc[trace_pkg::CNT_DROPPED] += 2'd1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // counter registers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_clear_i) begin
      cnt_q <= '0;
    end else if (!ev.debug_mode) begin
      for (int k = 0; k < 4; k++) begin
        cnt_q[k] <= cnt_q[k] + trace_pkg::CNT_W'(inc[k]);
      end
    end
  end

  assign cnt_rdata_o = cnt_q[cnt_sel_i];

endmodule

`default_nettype wire

/* logic/pc_rr_arbiter.sv */
/*
 * Round-robin merge of the per-port queue heads into one PC stream,
 * at most one PC per cycle, tagged with its source port.
 */

`timescale 1ns/1ns
`default_nettype none

module pc_rr_arbiter (
  input  wire logic                                                       clk_i,
  input  wire logic                                                       rst_ni,
  input  wire logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      head_valid_i,
  input  wire logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0] head_pc_i,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                           pop_o,
  output logic                                                            trace_valid_o,
  output logic [trace_pkg::VLEN-1:0]                                      trace_pc_o,
  output trace_pkg::port_idx_t                                            trace_port_o
);

  trace_pkg::port_idx_t rr_q;
  trace_pkg::port_idx_t gnt_idx;
  logic                 gnt_found;

  // ------------------------------------------------------------------------
  // grant the first valid head at or after the pointer
  // ------------------------------------------------------------------------
  always_comb begin
    int unsigned idx;
    gnt_found = 1'b0;
    gnt_idx   = rr_q;
    for (int unsigned off = 0; off < trace_pkg::NR_COMMIT_PORTS; off++) begin
      idx = (int'(rr_q) + off) % trace_pkg::NR_COMMIT_PORTS;
      if (!gnt_found && head_valid_i[idx]) begin
        gnt_found = 1'b1;
        gnt_idx   = trace_pkg::port_idx_t'(idx);
      end
    end
  end

  always_comb begin
    pop_o          = '0;
    pop_o[gnt_idx] = gnt_found;
  end

  assign trace_valid_o = gnt_found;
  assign trace_pc_o    = head_pc_i[gnt_idx];
  assign trace_port_o  = gnt_idx;

  // pointer moves past the granted port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (gnt_found) begin
      rr_q <= trace_pkg::port_idx_t'((int'(gnt_idx) + 1) % trace_pkg::NR_COMMIT_PORTS);
    end
  end

endmodule

`default_nettype wire

/* logic/commit_trace.sv */
/*
 * Retirement trace unit top. Classifies commits of a dual-commit core,
 * queues retired PCs per port, merges them and keeps event counters.
 */

`timescale 1ns/1ns
`default_nettype none

module commit_trace (
  input  wire logic                                                          clk_i,
  input  wire logic                                                          rst_ni,
  input  wire logic [trace_pkg::NR_COMMIT_PORTS-1:0]                         commit_ack_i,
  input  wire logic [trace_pkg::NR_COMMIT_PORTS-1:0]                         commit_ex_valid_i,
  input  wire logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0]    commit_pc_i,
  input  wire logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::CAUSE_W-1:0] commit_cause_i,
  input  wire logic                                                          debug_mode_i,
  input  wire trace_pkg::cnt_sel_e                                           cnt_sel_i,
  input  wire logic                                                          cnt_clear_i,
  output logic [trace_pkg::CNT_W-1:0]                                        cnt_rdata_o,
  output logic                                                               trace_valid_o,
  output logic [trace_pkg::VLEN-1:0]                                         trace_pc_o,
  output trace_pkg::port_idx_t                                               trace_port_o
);

  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      head_valid;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0] head_pc;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      pop;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                      drop;

  commit_event_if ev_if ();

  // ------------------------------------------------------------------------
  // input side
  // ------------------------------------------------------------------------
  commit_classify i_commit_classify (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_cause_i    ( commit_cause_i    ),
    .debug_mode_i      ( debug_mode_i      ),
    .ev                ( ev_if             )
  );

  // ------------------------------------------------------------------------
  // per-port PC queues and event counters
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < trace_pkg::NR_COMMIT_PORTS; i++) begin : gen_pc_queue
    pc_queue #(
      .PORT  ( trace_pkg::port_idx_t'(i) ),
      .DEPTH ( trace_pkg::PC_QUEUE_DEPTH )
    ) i_pc_queue (
      .clk_i        ( clk_i         ),
      .rst_ni       ( rst_ni        ),
      .ev           ( ev_if         ),
      .pop_i        ( pop[i]        ),
      .head_valid_o ( head_valid[i] ),
      .head_pc_o    ( head_pc[i]    ),
      .drop_o       ( drop[i]       )
    );
  end

  retire_counters i_retire_counters (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ev          ( ev_if       ),
    .drop_i      ( drop        ),
    .cnt_sel_i   ( cnt_sel_i   ),
    .cnt_clear_i ( cnt_clear_i ),
    .cnt_rdata_o ( cnt_rdata_o )
  );

  // ------------------------------------------------------------------------
  // output side
  // ------------------------------------------------------------------------
  pc_rr_arbiter i_pc_rr_arbiter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .head_valid_i  ( head_valid    ),
    .head_pc_i     ( head_pc       ),
    .pop_o         ( pop           ),
    .trace_valid_o ( trace_valid_o ),
    .trace_pc_o    ( trace_pc_o    ),
    .trace_port_o  ( trace_port_o  )
  );

endmodule

`default_nettype wire

/* tb/trace_model.svh */
/*
 * Reference model of the retirement trace unit. Expected PCs per port,
 * expected event counters and the value compare of the testbench.
 */

`ifndef TRACE_MODEL_SVH
`define TRACE_MODEL_SVH

// expected retired PCs per port with the oldest first
logic [trace_pkg::VLEN-1:0] exp_pc_q [trace_pkg::NR_COMMIT_PORTS][$];
// expected counters in cnt_sel_e order
int unsigned                exp_cnt [4];
int unsigned                exp_retired_total;
int unsigned                seen_total;
// PCs lost to a full queue are skipped in the overflow phase
bit                         allow_gaps;
string                      test_name;

task automatic abort_run(input string why);
  $display("%s", why);
  $display("tests failed");
  $fatal(1, "simulation stopped");
endtask

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual) begin
    $display("ERROR %s %s expected 0x%08h actual 0x%08h", test_name, what, expected, actual);
    abort_run("value mismatch");
  end
endtask

task automatic model_commit(input int port, input logic ex, input logic [31:0] cause,
                            input logic [31:0] pc, input logic dbg);
  int unsigned kind;
  if (!ex) begin
    kind = 0;
    exp_pc_q[port].push_back(pc);
    exp_retired_total++;
  end else if (cause[trace_pkg::CAUSE_W-1]) begin
    kind = 2;
  end else begin
    kind = 1;
  end
  // counting stops in debug mode
  if (!dbg) begin
    exp_cnt[kind]++;
  end
endtask

// one PC seen on the trace output
task automatic model_take(input int port, input logic [31:0] pc);
  logic [31:0] exp_pc;
  // trap PCs carry bit 0 set and must never show up
  check_value("retired pc bit 0", 32'd0, {31'd0, pc[0]});
  if (allow_gaps) begin
    while (exp_pc_q[port].size() > 0 && exp_pc_q[port][0] != pc) begin
      void'(exp_pc_q[port].pop_front());
    end
  end
  if (exp_pc_q[port].size() == 0) begin
    abort_run($sformatf("port %0d sent PC 0x%08h that was never expected", port, pc));
  end else begin
    exp_pc = exp_pc_q[port].pop_front();
    check_value($sformatf("trace_pc_o port %0d", port), exp_pc, pc);
  end
endtask

`endif

/* tb/tb_commit_trace.sv */
/*
 * Testbench for the retirement trace unit. Random commits on both ports,
 * PC stream and event counters checked against a reference model.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_commit_trace;

  logic                                                          clk_i;
  logic                                                          rst_ni;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                         commit_ack_i;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                         commit_ex_valid_i;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::VLEN-1:0]    commit_pc_i;
  logic [trace_pkg::NR_COMMIT_PORTS-1:0][trace_pkg::CAUSE_W-1:0] commit_cause_i;
  logic                                                          debug_mode_i;
  trace_pkg::cnt_sel_e                                           cnt_sel_i;
  logic                                                          cnt_clear_i;
  logic [trace_pkg::CNT_W-1:0]                                   cnt_rdata_o;
  logic                                                          trace_valid_o;
  logic [trace_pkg::VLEN-1:0]                                    trace_pc_o;
  trace_pkg::port_idx_t                                          trace_port_o;

  integer      seed = 37357;
  int unsigned pc_seq;

  `include "trace_model.svh"

  commit_trace i_dut (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_cause_i    ( commit_cause_i    ),
    .debug_mode_i      ( debug_mode_i      ),
    .cnt_sel_i         ( cnt_sel_i         ),
    .cnt_clear_i       ( cnt_clear_i       ),
    .cnt_rdata_o       ( cnt_rdata_o       ),
    .trace_valid_o     ( trace_valid_o     ),
    .trace_pc_o        ( trace_pc_o        ),
    .trace_port_o      ( trace_port_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // outputs are settled by the falling edge
  always @(negedge clk_i) begin
    if (rst_ni && trace_valid_o) begin
      seen_total++;
      model_take(int'(trace_port_o), trace_pc_o);
    end
  end

  function automatic int rand_bits(input int n);
    return $random(seed) & ((1 << n) - 1);
  endfunction

  // ------------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------------
  task automatic drive_cycle(input logic [1:0] ack, input logic [1:0] ex, input logic dbg);
    logic [31:0] pc;
    logic [31:0] cause;
    @(posedge clk_i);
    #1;
    debug_mode_i = dbg;
    for (int p = 0; p < 2; p++) begin
      pc_seq++;
      // bits 15:2 carry a unique sequence number
      // bit 0 marks a trap
      pc    = ($random(seed) & 32'hffff_0000) | (pc_seq << 2);
      cause = $random(seed);
      pc[0] = ack[p] && ex[p];
      commit_ack_i[p]      = ack[p];
      commit_ex_valid_i[p] = ex[p];
      commit_pc_i[p]       = pc;
      commit_cause_i[p]    = cause;
      if (ack[p]) begin
        model_commit(p, ex[p], cause, pc, dbg);
      end
    end
  endtask

  // each port commits at most every third cycle
  task automatic drive_mixed(input int cycles, input logic traps, input logic dbg);
    logic [1:0] ack;
    logic [1:0] ex;
    int         cool [2];
    cool[0] = 0;
    cool[1] = 0;
    repeat (cycles) begin
      ack = 2'b00;
      ex  = 2'b00;
      for (int p = 0; p < 2; p++) begin
        if (cool[p] > 0) begin
          cool[p]--;
        end else if (rand_bits(1) != 0) begin
          ack[p]  = 1'b1;
          ex[p]   = traps && (rand_bits(1) != 0);
          cool[p] = 2;
        end
      end
      drive_cycle(ack, ex, dbg);
    end
  endtask

  task automatic wait_drain();
    int idle;
    int cycles;
    idle   = 0;
    cycles = 0;
    drive_cycle(2'b00, 2'b00, 1'b0);
    while (idle < 4) begin
      @(negedge clk_i);
      cycles++;
      idle = trace_valid_o ? 0 : idle + 1;
      if (cycles > 300) begin
        abort_run({"timeout: trace output of ", test_name, " did not drain"});
      end
    end
  endtask

  task automatic read_counter(input trace_pkg::cnt_sel_e sel, output logic [31:0] value);
    @(posedge clk_i);
    #1;
    cnt_sel_i = sel;
    @(negedge clk_i);
    value = cnt_rdata_o;
  endtask

  task automatic check_counts();
    logic [31:0] value;
    for (int k = 0; k < 4; k++) begin
      read_counter(trace_pkg::cnt_sel_e'(k), value);
      check_value($sformatf("counter %0d", k), exp_cnt[k], value);
    end
  endtask

  task automatic check_drained();
    check_value("port 0 expected PCs left", 32'd0, exp_pc_q[0].size());
    check_value("port 1 expected PCs left", 32'd0, exp_pc_q[1].size());
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial begin
    logic [31:0] value;
    int unsigned base_seen;
    int unsigned base_total;
    rst_ni            = 1'b0;
    commit_ack_i      = '0;
    commit_ex_valid_i = '0;
    commit_pc_i       = '0;
    commit_cause_i    = '0;
    debug_mode_i      = 1'b0;
    cnt_sel_i         = trace_pkg::CNT_RETIRED;
    cnt_clear_i       = 1'b0;
    allow_gaps        = 1'b0;
    test_name         = "reset";
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("trace_valid_o", 32'd0, {31'd0, trace_valid_o});
    check_counts();

    test_name = "single_port";
    for (int n = 0; n < 40; n++) begin
      drive_cycle((n < 20) ? 2'b01 : 2'b10, 2'b00, 1'b0);
      repeat (1 + rand_bits(2)) drive_cycle(2'b00, 2'b00, 1'b0);
    end
    wait_drain();
    check_drained();
    check_counts();

    test_name = "both_ports";
    drive_mixed(90, 1'b0, 1'b0);
    wait_drain();
    check_drained();
    check_counts();

    test_name = "classification";
    drive_mixed(120, 1'b1, 1'b0);
    wait_drain();
    check_drained();
    check_counts();

    // both ports every cycle overrun the queues
    test_name  = "overflow";
    allow_gaps = 1'b1;
    base_seen  = seen_total;
    base_total = exp_retired_total;
    repeat (40) drive_cycle(2'b11, 2'b00, 1'b0);
    wait_drain();
    read_counter(trace_pkg::CNT_DROPPED, value);
    check_value("seen plus dropped", exp_retired_total - base_total,
                (seen_total - base_seen) + value);
    // retired PCs that never reached the output were lost to a full queue
    exp_cnt[3] += (exp_retired_total - base_total) - (seen_total - base_seen);
    check_counts();
    exp_pc_q[0].delete();
    exp_pc_q[1].delete();
    allow_gaps = 1'b0;

    test_name = "debug_freeze";
    drive_mixed(60, 1'b1, 1'b1);
    wait_drain();
    check_drained();
    check_counts();
    @(posedge clk_i);
    #1;
    cnt_clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    cnt_clear_i = 1'b0;
    for (int k = 0; k < 4; k++) begin
      exp_cnt[k] = 0;
    end
    test_name = "clear";
    check_counts();

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+tb
logic/trace_pkg.sv
logic/commit_event_if.sv
logic/commit_classify.sv
logic/pc_queue.sv
logic/retire_counters.sv
logic/pc_rr_arbiter.sv
logic/commit_trace.sv
tb/tb_commit_trace.sv

/* run.sh */
#!/bin/sh
# build the retirement trace testbench with Verilator and run it
# the exit status of the simulation is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f sources.f \
  --top-module tb_commit_trace -o sim_commit_trace &&
./obj_dir/sim_commit_trace || exit 1
